//--- include/node_config.svh
`ifndef NODE_CONFIG_SVH
`define NODE_CONFIG_SVH

// node memory size in bytes
`define NODE_MEM_BYTES 1024

// table base addresses, all word aligned
`define FLAG_ADDR      16'h0002  // aggregation flag word
`define SINK_BASE      16'h0008  // known sink ids
`define NEIGHBOR_BASE  16'h0048  // neighbor ids
`define CLUSTER_BASE   16'h00C8  // cluster id per neighbor

// table sizes in entries
`define NUM_NEIGHBORS  64
`define NUM_SINKS      16

// every entry is one 16-bit word, low byte first
`define WORD_BYTES     2

// value the scanner stores in the flag word on a match
`define FLAG_SET_VALUE 16'h0001

`endif

//--- logic/node_pkg.sv
package node_pkg;

	// one data word: table entry, cluster id or flag
	typedef logic [15:0] node_word_t;

	// byte address into the node memory
	typedef logic [15:0] node_addr_t;

	// index into the 64-entry neighbor table
	typedef logic [5:0] neighbor_idx_t;

	// scanner FSM states
	typedef enum logic [2:0] {
		idle,           // waiting for start, neighbor 0 address on the bus
		read_neighbor,  // neighbor id arrives
		read_cluster,   // cluster id arrives
		compare_sink,   // one known sink per cycle
		write_flag,     // store the flag word
		finish          // done high until start drops
	} scan_state_t;

endpackage

//--- logic/node_memory.sv
`timescale 1ns/1ps
`include "node_config.svh"

module node_memory (
	input  logic                 clock,
	input  logic                 nrst,
	input  node_pkg::node_addr_t host_addr,
	input  node_pkg::node_word_t host_wdata,
	input  logic                 host_wr_en,
	input  node_pkg::node_addr_t scan_addr,
	input  node_pkg::node_word_t scan_wdata,
	input  logic                 scan_wr_en,
	output node_pkg::node_word_t host_rdata,
	output node_pkg::node_word_t scan_rdata
);

	localparam int AW = $clog2(`NODE_MEM_BYTES);

	logic [7:0] mem [`NODE_MEM_BYTES];

	// byte addresses of the two halves of each port's word
	logic [AW-1:0] host_lo;
	logic [AW-1:0] host_hi;
	logic [AW-1:0] scan_lo;
	logic [AW-1:0] scan_hi;

	assign host_lo = {host_addr[AW-1:1], 1'b0};  // force even
	assign host_hi = {host_addr[AW-1:1], 1'b1};
	assign scan_lo = {scan_addr[AW-1:1], 1'b0};
	assign scan_hi = {scan_addr[AW-1:1], 1'b1};

	// writes, little endian
	always_ff @(posedge clock) begin
		if (host_wr_en) begin
			mem[host_lo] <= host_wdata[7:0];
			mem[host_hi] <= host_wdata[15:8];
		end
		if (scan_wr_en) begin  // later assignment, scanner wins a collision
			mem[scan_lo] <= scan_wdata[7:0];
			mem[scan_hi] <= scan_wdata[15:8];
		end
	end

	// registered reads, one cycle latency on both ports
	always_ff @(posedge clock) begin
		host_rdata <= {mem[host_hi], mem[host_lo]};
		scan_rdata <= {mem[scan_hi], mem[scan_lo]};
	end

	// host loads only while the scanner is idle, so the two never hit one word
	no_write_collision: assert property (
		@(posedge clock) disable iff (!nrst)
		!(host_wr_en && scan_wr_en && (host_addr[AW-1:1] == scan_addr[AW-1:1]))
	) else $error("host and scanner wrote the same word");

endmodule

//--- logic/aggregation_scanner.sv
`timescale 1ns/1ps
`include "node_config.svh"

module aggregation_scanner (
	input  logic                    clock,
	input  logic                    nrst,
	input  logic                    start,
	input  node_pkg::node_word_t    my_cluster_id,
	input  node_pkg::node_word_t    scan_rdata,
	output node_pkg::node_addr_t    scan_addr,
	output node_pkg::node_word_t    scan_wdata,
	output logic                    scan_wr_en,
	output logic                    done,
	output logic                    scan_busy,
	output logic                    for_aggregation,
	output node_pkg::neighbor_idx_t match_neighbor
);
	import node_pkg::*;

	localparam int SINK_W = $clog2(`NUM_SINKS);
	localparam neighbor_idx_t LAST_NEIGHBOR = neighbor_idx_t'(`NUM_NEIGHBORS - 1);
	localparam logic [SINK_W-1:0] LAST_SINK = SINK_W'(`NUM_SINKS - 1);

	scan_state_t       state;
	neighbor_idx_t     nbr_idx;
	logic [SINK_W-1:0] sink_idx;
	neighbor_idx_t     next_nbr;
	logic [SINK_W-1:0] next_sink;
	node_word_t        neighbor_id;
	node_word_t        cluster_id;
	logic              sink_hit;

	// byte address of entry idx in a word table
	function automatic node_addr_t entry_addr(input node_addr_t base, input neighbor_idx_t idx);
		return base + node_addr_t'(idx) * node_addr_t'(`WORD_BYTES);
	endfunction

	assign next_nbr  = nbr_idx + neighbor_idx_t'(1);
	assign next_sink = sink_idx + SINK_W'(1);

	// rdata holds sink sink_idx while in compare_sink
	assign sink_hit = (scan_rdata == neighbor_id) && (cluster_id != my_cluster_id);

	// address goes out one state ahead of the data it fetches
	always_comb begin
		scan_addr = node_addr_t'(`FLAG_ADDR);
		case (state)
			idle:          scan_addr = node_addr_t'(`NEIGHBOR_BASE);
			read_neighbor: scan_addr = entry_addr(`CLUSTER_BASE, nbr_idx);
			read_cluster:  scan_addr = entry_addr(`SINK_BASE, '0);
			compare_sink: begin
				if (sink_idx == LAST_SINK) begin
					scan_addr = entry_addr(`NEIGHBOR_BASE, next_nbr);  // prefetch next neighbor
				end else begin
					scan_addr = entry_addr(`SINK_BASE, neighbor_idx_t'(next_sink));
				end
			end
			default:       scan_addr = node_addr_t'(`FLAG_ADDR);
		endcase
	end

	assign scan_wr_en = (state == write_flag);
	assign scan_wdata = `FLAG_SET_VALUE;
	assign done       = (state == finish);
	assign scan_busy  = (state != idle) && (state != finish);

	// captured table entries for the current neighbor
	always_ff @(posedge clock) begin
		if (state == read_neighbor) begin
			neighbor_id <= scan_rdata;
		end
		if (state == read_cluster) begin
			cluster_id <= scan_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state           <= idle;
			nbr_idx         <= '0;
			sink_idx        <= '0;
			for_aggregation <= 1'b0;
			match_neighbor  <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						nbr_idx         <= '0;
						sink_idx        <= '0;
						for_aggregation <= 1'b0;  // old results dropped on accept
						match_neighbor  <= '0;
						state           <= read_neighbor;
					end
				end
				read_neighbor: state <= read_cluster;
				read_cluster: begin
					sink_idx <= '0;
					state    <= compare_sink;
				end
				compare_sink: begin
					if (sink_hit) begin
						for_aggregation <= 1'b1;
						match_neighbor  <= nbr_idx;
						state           <= write_flag;
					end else if (sink_idx == LAST_SINK) begin
						sink_idx <= '0;
						if (nbr_idx == LAST_NEIGHBOR) begin
							state <= finish;  // table exhausted, no match
						end else begin
							nbr_idx <= next_nbr;
							state   <= read_neighbor;
						end
					end else begin
						sink_idx <= next_sink;
					end
				end
				write_flag: state <= finish;
				finish: begin
					if (!start) begin  // host released start
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// a write only follows a sink hit and goes to the flag word
	flag_write_only: assert property (
		@(posedge clock) disable iff (!nrst)
		scan_wr_en |-> $past(state == compare_sink && sink_hit) && for_aggregation
			&& (scan_addr == node_addr_t'(`FLAG_ADDR))
	) else $error("scanner write without a sink hit or outside FLAG_ADDR");

	// four-phase: done only answers a held start
	done_follows_start: assert property (
		@(posedge clock) disable iff (!nrst)
		$rose(done) |-> start
	) else $error("done rose without start");

endmodule

//--- logic/cluster_node_top.sv
`timescale 1ns/1ps

module cluster_node_top (
	input  logic                    clock,
	input  logic                    nrst,
	input  node_pkg::node_addr_t    host_addr,
	input  node_pkg::node_word_t    host_wdata,
	input  logic                    host_wr_en,
	output node_pkg::node_word_t    host_rdata,
	input  logic                    start,
	input  node_pkg::node_word_t    my_cluster_id,
	output logic                    done,
	output logic                    scan_busy,
	output logic                    for_aggregation,
	output node_pkg::neighbor_idx_t match_neighbor
);
	import node_pkg::*;

	// scanner side of the memory
	node_addr_t scan_addr;
	node_word_t scan_wdata;
	node_word_t scan_rdata;
	logic       scan_wr_en;

	node_memory node_memory_i (
		.clock      (clock),
		.nrst       (nrst),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_wr_en (host_wr_en),
		.scan_addr  (scan_addr),
		.scan_wdata (scan_wdata),
		.scan_wr_en (scan_wr_en),
		.host_rdata (host_rdata),
		.scan_rdata (scan_rdata)
	);

	aggregation_scanner aggregation_scanner_i (
		.clock           (clock),
		.nrst            (nrst),
		.start           (start),
		.my_cluster_id   (my_cluster_id),
		.scan_rdata      (scan_rdata),
		.scan_addr       (scan_addr),
		.scan_wdata      (scan_wdata),
		.scan_wr_en      (scan_wr_en),
		.done            (done),
		.scan_busy       (scan_busy),
		.for_aggregation (for_aggregation),
		.match_neighbor  (match_neighbor)
	);

endmodule

//--- tb/cluster_node_tb.sv
`timescale 1ns/1ps
`include "node_config.svh"

module cluster_node_tb;
	import node_pkg::*;

	localparam int CLK_PERIOD  = 4;
	localparam int CLEAR_WORDS = (`CLUSTER_BASE + `WORD_BYTES * `NUM_NEIGHBORS) / `WORD_BYTES;

	logic          clock;
	logic          nrst;
	node_addr_t    host_addr;
	node_word_t    host_wdata;
	logic          host_wr_en;
	node_word_t    host_rdata;
	logic          start;
	node_word_t    my_cluster_id;
	logic          done;
	logic          scan_busy;
	logic          for_aggregation;
	neighbor_idx_t match_neighbor;

	// pattern file contents, one entry per test
	string         test_name[$];
	node_word_t    test_cluster[$];
	int            test_first[$];  // first write of the test
	int            test_count[$];
	node_word_t    exp_flag[$];
	logic          exp_agg[$];
	neighbor_idx_t exp_match[$];
	node_addr_t    wr_addr[$];
	node_word_t    wr_data[$];

	int word_errors;
	int index_errors;
	int bit_errors;
	int other_errors;
	bit tests_loaded;

	cluster_node_top cluster_node_top_i (
		.clock           (clock),
		.nrst            (nrst),
		.host_addr       (host_addr),
		.host_wdata      (host_wdata),
		.host_wr_en      (host_wr_en),
		.host_rdata      (host_rdata),
		.start           (start),
		.my_cluster_id   (my_cluster_id),
		.done            (done),
		.scan_busy       (scan_busy),
		.for_aggregation (for_aggregation),
		.match_neighbor  (match_neighbor)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic compare_word(input string what, input node_word_t expected,
			input node_word_t actual);
		if (actual !== expected) begin
			word_errors++;
			$display("** Error %0s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	task automatic compare_index(input string what, input neighbor_idx_t expected,
			input neighbor_idx_t actual);
		if (actual !== expected) begin
			index_errors++;
			$display("** Error %0s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic compare_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			bit_errors++;
			$display("** Error %0s: expected %b, actual %b", what, expected, actual);
		end
	endtask

	task automatic host_write(input node_addr_t addr, input node_word_t data);
		@(posedge clock);
		host_addr  <= addr;
		host_wdata <= data;
		host_wr_en <= 1'b1;
	endtask

	task automatic host_read(input node_addr_t addr, output node_word_t data);
		@(posedge clock);
		host_addr  <= addr;
		host_wr_en <= 1'b0;
		@(posedge clock);  // word registered here
		@(negedge clock);
		data = host_rdata;
	endtask

	// flag word, sinks, neighbor ids and cluster ids
	task automatic clear_tables;
		int i;
		for (i = 0; i < CLEAR_WORDS; i++) begin
			host_write(node_addr_t'(`WORD_BYTES * i), '0);
		end
	endtask

	task automatic load_patterns;
		int fd;
		int n;
		int want;
		string line;
		logic [8*24-1:0] name_tok;
		node_word_t cl;
		int cnt;
		node_addr_t a;
		node_word_t d;
		logic g;
		neighbor_idx_t m;
		fd = $fopen("tb/scan_patterns.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("cannot open tb/scan_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() >= 2 && line.getc(0) != "#") begin
					name_tok = '0;
					case (line.getc(0))
						"T": begin
							want = 4;
							n = $sscanf(line, "T %s %h %d", name_tok, cl, cnt) + 1;
							test_name.push_back($sformatf("%0s", name_tok));
							test_cluster.push_back(cl);
							test_first.push_back(wr_addr.size());
							test_count.push_back(cnt);
						end
						"W": begin
							want = 3;
							n = $sscanf(line, "W %h %h", a, d) + 1;
							wr_addr.push_back(a);
							wr_data.push_back(d);
						end
						"E": begin
							want = 4;
							n = $sscanf(line, "E %h %h %h", d, g, m) + 1;
							exp_flag.push_back(d);
							exp_agg.push_back(g);
							exp_match.push_back(m);
							if (wr_addr.size() != test_first[$] + test_count[$]) begin
								want = -1;  // write count disagrees with W lines
							end
						end
						default: begin
							want = -1;
							n = 0;
						end
					endcase
					if (n != want) begin
						other_errors++;
						$display("malformed pattern line: %0s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// four-phase start/done with result checks on both sides of the drop
	task automatic run_scan(input string name, input node_word_t cluster, input logic agg,
			input neighbor_idx_t match);
		int i;
		@(posedge clock);
		my_cluster_id <= cluster;
		start         <= 1'b1;
		@(negedge clock);
		@(negedge clock);  // start taken on the edge in between
		compare_bit({name, " scan_busy"}, 1'b1, scan_busy);
		while (!done) @(negedge clock);
		for (i = 0; i < 3; i++) begin  // start still held
			@(negedge clock);
			if (!done) begin
				other_errors++;
				$display("%0s: done dropped while start was still high", name);
			end
		end
		compare_bit({name, " for_aggregation"}, agg, for_aggregation);
		compare_index({name, " match_neighbor"}, match, match_neighbor);
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		while (done) @(negedge clock);
		if (scan_busy) begin
			other_errors++;
			$display("%0s: scanner still busy after done fell", name);
		end
		compare_bit({name, " held for_aggregation"}, agg, for_aggregation);
		compare_index({name, " held match_neighbor"}, match, match_neighbor);
	endtask

	initial begin
		wait (tests_loaded);
		#((test_name.size() * 1200 + 1000) * CLK_PERIOD);
		$display("timeout: scanner stuck in state %s",
			cluster_node_top_i.aggregation_scanner_i.state.name());
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		node_word_t    rd;
		logic          prev_agg;
		neighbor_idx_t prev_match;
		int            t;
		int            k;
		int            w;
		nrst          <= 1'b0;
		host_addr     <= '0;
		host_wdata    <= '0;
		host_wr_en    <= 1'b0;
		start         <= 1'b0;
		my_cluster_id <= '0;
		word_errors  = 0;
		index_errors = 0;
		bit_errors   = 0;
		other_errors = 0;
		prev_agg     = 1'b0;  // reset values
		prev_match   = '0;
		load_patterns();
		if (test_name.size() == 0) begin
			other_errors++;
			$display("no tests found in the pattern file");
		end
		if (exp_flag.size() != test_name.size()) begin
			other_errors++;
			$display("pattern file has %0d tests but %0d result lines",
				test_name.size(), exp_flag.size());
		end
		tests_loaded = 1'b1;
		repeat (5) @(posedge clock);
		nrst <= 1'b1;
		@(negedge clock);
		compare_bit("reset done", 1'b0, done);
		compare_bit("reset scan_busy", 1'b0, scan_busy);

		for (t = 0; t < test_name.size(); t++) begin
			clear_tables();
			for (k = 0; k < test_count[t]; k++) begin
				w = test_first[t] + k;
				host_write(wr_addr[w], wr_data[w]);
			end
			@(posedge clock);
			host_wr_en <= 1'b0;
			for (k = 0; k < test_count[t]; k++) begin
				w = test_first[t] + k;
				host_read(wr_addr[w], rd);
				compare_word({test_name[t], " readback"}, wr_data[w], rd);
			end
			@(negedge clock);  // last results must survive the table reload
			compare_bit({test_name[t], " before start for_aggregation"}, prev_agg,
				for_aggregation);
			compare_index({test_name[t], " before start match_neighbor"}, prev_match,
				match_neighbor);
			run_scan(test_name[t], test_cluster[t], exp_agg[t], exp_match[t]);
			host_read(node_addr_t'(`FLAG_ADDR), rd);
			compare_word({test_name[t], " flag"}, exp_flag[t], rd);
			prev_agg   = exp_agg[t];
			prev_match = exp_match[t];
		end

		$display("errors: word %0d, index %0d, bit %0d, other %0d",
			word_errors, index_errors, bit_errors, other_errors);
		if (word_errors + index_errors + bit_errors + other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- tb/scan_patterns.txt
# T name my_cluster_id write_count, then write_count lines W byte_addr word
# E expected_flag expected_for_aggregation expected_match_neighbor, all hex
T no_match 0000 0
E 0000 0 00
T single_foreign 0000 3
W 000e a5c3
W 005a a5c3
W 00da 0007
E 0001 1 09
T same_cluster 0000 3
W 0012 1234
W 0070 1234
W 00f0 0000
E 0000 0 00
T several_candidates 0000 8
W 0008 0bee
W 0026 0c0c
W 0084 0c0c
W 0104 0002
W 0060 0bee
W 00e0 0003
W 0052 0bee
W 00d2 0000
E 0001 1 0c
T last_index 0000 3
W 0026 7e7e
W 00c6 7e7e
W 0146 0001
E 0001 1 3f
T zero_ids_foreign 0042 0
E 0001 1 00
T skip_own_cluster 0042 1
W 00c8 0042
E 0001 1 01
T host_readback 0000 7
W 03fe beef
W 0200 1357
W 0004 cafe
W 0148 55aa
W 000a 4444
W 0098 4444
W 0118 0010
E 0001 1 28

//--- cluster_node_top.f
+incdir+include
logic/node_pkg.sv
logic/node_memory.sv
logic/aggregation_scanner.sv
logic/cluster_node_top.sv
tb/cluster_node_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cluster node testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f cluster_node_top.f --top-module cluster_node_tb \
	--Mdir obj_dir -o cluster_node_sim

output=$(./obj_dir/cluster_node_sim)
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
